/* machine_trap_unit.f */
src/machine_trap_pkg.sv
src/exception_prioritizer.sv
src/interrupt_arbiter.sv
src/trap_control.sv
src/machine_csr_file.sv
src/machine_trap_unit.sv
sim/machine_trap_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the machine trap unit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module machine_trap_unit_tb \
  -f machine_trap_unit.f \
  -o machine_trap_unit_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/machine_trap_unit_sim 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test completed successfully"; then
  exit 0
fi
exit 1

/* sim/machine_trap_unit_tb.sv */
// testbench for the machine trap unit
// replays the steps of the data file, Wishbone CSR accesses and pipeline
// cycles, and compares trap, redirect and read data with the expected values
`timescale 1ns/1ps
`default_nettype none

module machine_trap_unit_tb;

  logic        clk;
  logic        arst_n;
  logic [31:0] pc;
  logic [31:0] bad_addr;
  logic        mal_insn, fault_insn, illegal_insn, breakpoint, env_m;
  logic        mal_l, fault_l, mal_s, fault_s;
  logic        mret;
  logic        trap, redirect;
  logic [31:0] redirect_pc;
  logic        timer_irq, soft_irq, ext_irq;
  logic        wb_cyc, wb_stb, wb_we;
  logic [31:0] wb_adr, wb_dat_w, wb_dat_r;
  logic [3:0]  wb_sel;
  logic        wb_ack;

  string       steps[$];           // data lines that hold an operation
  int          cycle_count = 0;
  int          cycle_limit = 100;  // raised once the data file is read

  machine_trap_unit #(.reset_mtvec(32'h0000_0100)) DUT (.*);

  always #2 clk = ~clk;  // 4 ns period

  // a step that never finishes would otherwise hang the run
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      stop_run_failed($sformatf("no progress after %0d cycles, the run was stopped", cycle_limit));
    end
  end

  task automatic stop_run_failed(input string what);
    $display("%s", what);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_run_failed($sformatf("[ERROR] %0t: %s is %b, expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      stop_run_failed($sformatf("[ERROR] %0t: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  // the interrupt bit picks which view of the word is meaningful
  function automatic string describe_cause(input machine_trap_pkg::mcause_t c);
    if (c.irq.interrupt) begin
      return $sformatf("%h (interrupt, code %0d)", c, c.irq.cause);
    end
    return $sformatf("%h (exception, code %0d)", c, c.ex.cause);
  endfunction

  task automatic check_cause(input string name, input machine_trap_pkg::mcause_t got,
                             input machine_trap_pkg::mcause_t exp);
    if (got !== exp) begin
      stop_run_failed($sformatf("[ERROR] %0t: %s is %s, expected %s", $time, name,
                                describe_cause(got), describe_cause(exp)));
    end
  endtask

  // one Wishbone classic cycle, entered and left 1 ns after a rising edge
  task automatic bus_access(input logic we, input machine_trap_pkg::csr_addr_t addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int latency;
    latency  = 0;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_sel   = 4'hf;  // word accesses only
    wb_adr   = {18'd0, addr, 2'b00};
    wb_dat_w = wdata;
    while (wb_ack !== 1'b1) begin
      @(posedge clk);
      #1;
      latency++;
    end
    if (latency != 1) begin
      stop_run_failed($sformatf("wishbone ack came %0d cycles after the request instead of 1",
                                latency));
    end
    rdata  = wb_dat_r;  // registered, so stable for the whole ack cycle
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    @(posedge clk);
    #1;
    check_bit("wb_ack", wb_ack, 1'b0);  // ack is a single pulse
  endtask

  // one pipeline cycle, outputs are combinational so they are sampled late in it
  task automatic pipeline_step(input logic [8:0] flags, input logic [31:0] step_pc,
                               input logic [31:0] step_bad, input logic step_mret,
                               input logic [2:0] irq, input logic exp_trap,
                               input logic exp_redirect, input logic [31:0] exp_pc);
    {mal_insn, fault_insn, illegal_insn, breakpoint, env_m,
     mal_l, fault_l, mal_s, fault_s} = flags;
    {ext_irq, soft_irq, timer_irq}   = irq;  // levels, they stay until the next step
    pc       = step_pc;
    bad_addr = step_bad;
    mret     = step_mret;
    #2;
    check_bit("trap", trap, exp_trap);
    check_bit("redirect", redirect, exp_redirect);
    if (exp_redirect) begin
      check_word("redirect_pc", redirect_pc, exp_pc);  // only valid with redirect
    end
    @(posedge clk);
    #1;
    {mal_insn, fault_insn, illegal_insn, breakpoint, env_m,
     mal_l, fault_l, mal_s, fault_s} = '0;
    mret = 1'b0;
  endtask

  initial begin
    int                        fd;
    string                     line;
    string                     op;
    int                        ops_run;
    logic [31:0]               f1, f2, f3, rd;
    logic [8:0]                flags;
    logic                      step_mret, exp_trap, exp_redirect;
    logic [2:0]                irq;
    machine_trap_pkg::mcause_t cause_got, cause_exp;

    clk = 1'b0;
    arst_n = 1'b0;
    pc = '0;
    bad_addr = '0;
    {mal_insn, fault_insn, illegal_insn, breakpoint, env_m} = '0;
    {mal_l, fault_l, mal_s, fault_s} = '0;
    mret = 1'b0;
    {timer_irq, soft_irq, ext_irq} = '0;
    {wb_cyc, wb_stb, wb_we} = '0;
    wb_adr = '0;
    wb_dat_w = '0;
    wb_sel = '0;
    ops_run = 0;

    fd = $fopen("sim/machine_trap_unit_testdata.txt", "r");
    if (fd == 0) begin
      stop_run_failed("could not open sim/machine_trap_unit_testdata.txt");
    end
    while (!$feof(fd)) begin
      if ($fgets(line, fd) > 0) begin
        if ($sscanf(line, "%s", op) == 1 && op.substr(0, 0) != "#") begin
          steps.push_back(line);  // blank and comment lines are dropped
        end
      end
    end
    $fclose(fd);
    cycle_limit = steps.size() * 4 + 100;

    repeat (10) @(posedge clk);
    #1;
    arst_n = 1'b1;
    check_bit("trap", trap, 1'b0);
    check_bit("redirect", redirect, 1'b0);
    check_bit("wb_ack", wb_ack, 1'b0);

    foreach (steps[i]) begin
      void'($sscanf(steps[i], "%s", op));
      if (op == "W" && $sscanf(steps[i], "%s %h %h", op, f1, f2) == 3) begin
        bus_access(1'b1, f1[11:0], f2, rd);
      end else if (op == "R" && $sscanf(steps[i], "%s %h %h", op, f1, f2) == 3) begin
        bus_access(1'b0, f1[11:0], '0, rd);
        check_word($sformatf("wb_dat_r of csr %h", f1[11:0]), rd, f2);
      end else if (op == "C" && $sscanf(steps[i], "%s %h", op, f1) == 2) begin
        bus_access(1'b0, machine_trap_pkg::CSR_MCAUSE, '0, rd);
        cause_got = rd;
        cause_exp = f1;
        check_cause("mcause", cause_got, cause_exp);
      end else if (op == "P" && $sscanf(steps[i], "%s %b %h %h %b %b %b %b %h", op, flags, f1,
                                        f2, step_mret, irq, exp_trap, exp_redirect, f3) == 9) begin
        pipeline_step(flags, f1, f2, step_mret, irq, exp_trap, exp_redirect, f3);
      end else begin
        stop_run_failed($sformatf("data line %0d cannot be parsed: %s", i + 1, steps[i]));
      end
      ops_run++;
    end

    if (ops_run == 0) begin
      stop_run_failed("the data file held no test steps");
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* sim/machine_trap_unit_testdata.txt */
# W csr data | R csr expected | C expected_mcause | P flags pc bad_addr mret irq trap redirect redirect_pc
# flags: mal_insn fault_insn illegal_insn breakpoint env_m mal_l fault_l mal_s fault_s; irq: ext soft timer
R 305 00000100
R 300 00000000
R 304 00000000
R 341 00000000
R 342 00000000
R 343 00000000
R 344 00000000
R 7ff 00000000
W 305 00000203
R 305 00000200
W 304 00000888
R 304 00000888
W 343 12345678
R 343 00000000
W 342 0000000f
C 00000000
P 101000100 00001000 0000abcd 0 000 1 1 00000200
C 00000005
R 341 00001000
R 343 0000abcd
P 000110010 00002000 00000044 0 000 1 1 00000200
C 00000006
R 341 00002000
P 001110000 00003000 00000055 0 000 1 1 00000200
C 00000003
R 341 00003004
R 343 00000000
P 000010000 00004ffc 00000000 0 000 1 1 00000200
C 0000000b
R 341 00005000
P 110000000 00006000 00000077 0 000 1 1 00000200
C 00000001
R 343 00006000
P 000000001 00007000 0000beef 0 000 1 1 00000200
C 00000007
R 343 0000beef
R 300 00000000
P 000000000 00008000 00000000 0 100 0 0 00000000
P 000000000 00008004 00000000 0 100 0 0 00000000
R 344 00000800
P 000000000 00008008 00000000 0 000 0 0 00000000
W 300 00000008
R 300 00000008
P 000000000 00009000 00000000 0 111 0 0 00000000
P 000000000 00009004 00000000 0 111 1 1 00000200
C 8000000b
R 341 00009004
R 300 00000080
R 343 0000beef
P 000000000 0000a000 00000000 1 000 0 1 00009004
R 300 00000088
P 000000000 0000b000 00000000 0 001 0 0 00000000
P 001000000 0000b004 00000000 0 001 1 1 00000200
C 00000002
R 341 0000b004
R 300 00000080
P 001000000 0000c000 00000000 1 000 1 1 00000200
R 300 00000000
C 00000002
R 341 0000c000

/* src/exception_prioritizer.sv */
// exception prioritizer
// reduces the nine exception flags of the current instruction to one
// winning cause, memory faults first and instruction fetch faults last
`timescale 1ns/1ps
`default_nettype none

module exception_prioritizer (
  input  wire logic                       mal_insn,
  input  wire logic                       fault_insn,
  input  wire logic                       illegal_insn,
  input  wire logic                       breakpoint,
  input  wire logic                       env_m,
  input  wire logic                       mal_l,
  input  wire logic                       fault_l,
  input  wire logic                       mal_s,
  input  wire logic                       fault_s,
  output      logic                       exc_valid,
  output      machine_trap_pkg::ex_code_t exc_code
);

  // fixed priority chain, the first flag that is set wins
  always_comb begin
    exc_valid = 1'b1;
    exc_code  = machine_trap_pkg::INSN_MAL;  // default keeps the code stable when idle
    if (fault_l) begin
      exc_code = machine_trap_pkg::L_FAULT;
    end else if (mal_l) begin
      exc_code = machine_trap_pkg::L_ADDR_MAL;
    end else if (fault_s) begin
      exc_code = machine_trap_pkg::S_FAULT;
    end else if (mal_s) begin
      exc_code = machine_trap_pkg::S_ADDR_MAL;
    end else if (breakpoint) begin
      exc_code = machine_trap_pkg::BREAKPOINT;
    end else if (env_m) begin
      exc_code = machine_trap_pkg::ENV_CALL_M;
    end else if (illegal_insn) begin
      exc_code = machine_trap_pkg::ILLEGAL_INSN;
    end else if (fault_insn) begin
      exc_code = machine_trap_pkg::INSN_FAULT;
    end else if (mal_insn) begin
      exc_code = machine_trap_pkg::INSN_MAL;
    end else begin
      exc_valid = 1'b0;  // nothing raised this cycle
    end
  end

  // the chain must not drop a flag, so valid has to match a plain OR
  always_comb begin : chk_valid
    a_valid_is_or : assert #0 (exc_valid == (mal_insn | fault_insn | illegal_insn |
                                             breakpoint | env_m | mal_l | fault_l |
                                             mal_s | fault_s))
      else $error("exception valid does not match the raised flags");
  end

endmodule

`default_nettype wire

/* src/interrupt_arbiter.sv */
// interrupt arbiter
// masks pending machine interrupts with their enables and the global
// enable, then picks external, software and timer in that order
`timescale 1ns/1ps
`default_nettype none

module interrupt_arbiter (
  input  wire logic [31:0]                 mip,
  input  wire logic [31:0]                 mie,
  input  wire logic                        mstatus_mie,
  output      logic                        irq_valid,
  output      machine_trap_pkg::int_code_t irq_code
);

  logic [31:0] pend;  // pending and enabled, before the priority pick

  assign pend = mip & mie & {32{mstatus_mie}};  // global enable kills everything

  always_comb begin
    irq_valid = 1'b1;
    irq_code  = machine_trap_pkg::SOFT_INT;
    if (pend[machine_trap_pkg::MIP_MEIP_BIT]) begin
      irq_code = machine_trap_pkg::EXT_INT;  // platform interrupt first
    end else if (pend[machine_trap_pkg::MIP_MSIP_BIT]) begin
      irq_code = machine_trap_pkg::SOFT_INT;
    end else if (pend[machine_trap_pkg::MIP_MTIP_BIT]) begin
      irq_code = machine_trap_pkg::TIMER_INT;  // timer is the lowest here
    end else begin
      irq_valid = 1'b0;
    end
  end

  // a request with the global enable off would trap with interrupts disabled
  always_comb begin : chk_gate
    a_no_irq_when_disabled : assert #0 (!(irq_valid && !mstatus_mie))
      else $error("interrupt requested while mstatus.mie is clear");
  end

endmodule

`default_nettype wire

/* src/machine_csr_file.sv */
// machine CSR file
// holds mstatus, mie, mip, mtvec, mepc, mcause and mtval, applies the
// trap and mret updates and serves a Wishbone classic slave port with
// a registered ack one cycle after the request
`timescale 1ns/1ps
`default_nettype none

module machine_csr_file #(
  parameter logic [31:0] reset_mtvec = 32'h0000_0100
) (
  input  wire logic                      clk,
  input  wire logic                      arst_n,
  input  wire logic                      wb_cyc,
  input  wire logic                      wb_stb,
  input  wire logic                      wb_we,
  input  wire logic [31:0]               wb_adr,
  input  wire logic [31:0]               wb_dat_w,
  input  wire logic [3:0]                wb_sel,
  output      logic [31:0]               wb_dat_r,
  output      logic                      wb_ack,
  input  wire logic                      timer_irq,
  input  wire logic                      soft_irq,
  input  wire logic                      ext_irq,
  input  wire logic                      trap_take,
  input  wire machine_trap_pkg::mcause_t mcause_next,
  input  wire logic [31:0]               mepc_next,
  input  wire logic                      mtval_write,
  input  wire logic [31:0]               mtval_next,
  input  wire logic                      ret_take,
  output      logic [31:0]               mip,
  output      logic [31:0]               mie,
  output      logic                      mstatus_mie,
  output      logic [31:0]               mtvec,
  output      logic [31:0]               mepc
);

  machine_trap_pkg::csr_addr_t csr_addr;
  machine_trap_pkg::mcause_t   mcause;
  logic                        mstatus_mpie;
  logic [31:0]                 mtval;
  logic                        wb_req;   // new request, not yet acked
  logic                        wb_wr;
  logic [31:0]                 rd_data;

  assign csr_addr = wb_adr[13:2];  // word address carries the CSR number
  assign wb_req   = wb_cyc & wb_stb & ~wb_ack;  // stb is still up in the ack cycle
  assign wb_wr    = wb_req & wb_we;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= wb_req;  // exactly one cycle after the request
    end
  end

  // trap first, then mret, then the bus
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mstatus_mie  <= 1'b0;
      mstatus_mpie <= 1'b0;
    end else if (trap_take) begin
      mstatus_mie  <= 1'b0;
      mstatus_mpie <= mstatus_mie;  // one level of enable stack
    end else if (ret_take) begin
      mstatus_mie  <= mstatus_mpie;
      mstatus_mpie <= 1'b1;
    end else if (wb_wr && csr_addr == machine_trap_pkg::CSR_MSTATUS) begin
      mstatus_mie  <= wb_dat_w[machine_trap_pkg::MSTATUS_MIE_BIT];
      mstatus_mpie <= wb_dat_w[machine_trap_pkg::MSTATUS_MPIE_BIT];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mie   <= '0;
      mtvec <= {reset_mtvec[31:2], 2'b00};
    end else if (wb_wr) begin
      if (csr_addr == machine_trap_pkg::CSR_MIE) begin
        mie <= wb_dat_w;
      end
      if (csr_addr == machine_trap_pkg::CSR_MTVEC) begin
        mtvec <= {wb_dat_w[31:2], 2'b00};  // mode bits pinned to direct
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mepc   <= '0;
      mcause <= '0;
      mtval  <= '0;
    end else begin
      if (trap_take) begin
        mepc   <= mepc_next;
        mcause <= mcause_next;
      end else if (wb_wr && csr_addr == machine_trap_pkg::CSR_MEPC) begin
        mepc <= wb_dat_w;
      end
      if (mtval_write) begin
        mtval <= mtval_next;  // only the trap path writes mtval
      end
    end
  end

  // the lines are levels, mip just mirrors them one cycle late
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mip <= '0;
    end else begin
      mip                                 <= '0;
      mip[machine_trap_pkg::MIP_MSIP_BIT] <= soft_irq;
      mip[machine_trap_pkg::MIP_MTIP_BIT] <= timer_irq;
      mip[machine_trap_pkg::MIP_MEIP_BIT] <= ext_irq;  // external goes to meip
    end
  end

  always_comb begin
    rd_data = '0;  // unknown numbers read as zero
    case (csr_addr)
      machine_trap_pkg::CSR_MSTATUS: begin
        rd_data[machine_trap_pkg::MSTATUS_MIE_BIT]  = mstatus_mie;
        rd_data[machine_trap_pkg::MSTATUS_MPIE_BIT] = mstatus_mpie;
      end
      machine_trap_pkg::CSR_MIE:    rd_data = mie;
      machine_trap_pkg::CSR_MIP:    rd_data = mip;
      machine_trap_pkg::CSR_MTVEC:  rd_data = mtvec;
      machine_trap_pkg::CSR_MEPC:   rd_data = mepc;
      machine_trap_pkg::CSR_MCAUSE: rd_data = mcause;
      machine_trap_pkg::CSR_MTVAL:  rd_data = mtval;
      default:                      rd_data = '0;
    endcase
  end

  // read data rides with the ack
  always_ff @(posedge clk) begin
    if (wb_req) begin
      wb_dat_r <= rd_data;
    end
  end

  a_ack_single : assert property (@(posedge clk) disable iff (!arst_n)
    wb_ack |=> !wb_ack)
    else $error("wishbone ack held for two cycles");

  a_ack_after_req : assert property (@(posedge clk) disable iff (!arst_n)
    wb_ack |-> $past(wb_cyc && wb_stb))
    else $error("wishbone ack without a request");

  // only full word writes are supported
  a_full_word_write : assert property (@(posedge clk) disable iff (!arst_n)
    (wb_cyc && wb_stb && wb_we) |-> (wb_sel == 4'hf))
    else $error("partial wishbone write");

endmodule

`default_nettype wire

/* src/machine_trap_pkg.sv */
// machine trap package
// cause codes, CSR numbers and bit positions shared by the machine-mode
// trap unit, plus the mcause word with its exception and interrupt views
`default_nettype none

package machine_trap_pkg;

  // synchronous exception causes, numbered as in the privileged spec
  typedef enum logic [3:0] {
    INSN_MAL     = 4'd0,
    INSN_FAULT   = 4'd1,
    ILLEGAL_INSN = 4'd2,
    BREAKPOINT   = 4'd3,
    L_ADDR_MAL   = 4'd4,
    L_FAULT      = 4'd5,
    S_ADDR_MAL   = 4'd6,
    S_FAULT      = 4'd7,
    ENV_CALL_M   = 4'd11
  } ex_code_t;

  // asynchronous causes, machine level only
  typedef enum logic [3:0] {
    SOFT_INT  = 4'd3,
    TIMER_INT = 4'd7,
    EXT_INT   = 4'd11
  } int_code_t;

  typedef struct packed {
    logic        interrupt;  // always 0 in this view
    logic [26:0] reserved;
    ex_code_t    cause;
  } mcause_ex_t;

  typedef struct packed {
    logic        interrupt;  // always 1 in this view
    logic [26:0] reserved;
    int_code_t   cause;
  } mcause_irq_t;

  // the same word read two ways, the top bit picks which view is valid
  typedef union packed {
    mcause_ex_t  ex;
    mcause_irq_t irq;
  } mcause_t;

  typedef logic [11:0] csr_addr_t;  // CSR number, carried in wb_adr[13:2]

  localparam csr_addr_t CSR_MSTATUS = 12'h300;
  localparam csr_addr_t CSR_MIE     = 12'h304;
  localparam csr_addr_t CSR_MTVEC   = 12'h305;
  localparam csr_addr_t CSR_MEPC    = 12'h341;
  localparam csr_addr_t CSR_MCAUSE  = 12'h342;
  localparam csr_addr_t CSR_MTVAL   = 12'h343;
  localparam csr_addr_t CSR_MIP     = 12'h344;

  // mstatus fields
  localparam int unsigned MSTATUS_MIE_BIT  = 3;
  localparam int unsigned MSTATUS_MPIE_BIT = 7;

  // mip fields, mie enables sit at the same positions
  localparam int unsigned MIP_MSIP_BIT = 3;
  localparam int unsigned MIP_MTIP_BIT = 7;
  localparam int unsigned MIP_MEIP_BIT = 11;

endpackage

`default_nettype wire

/* src/machine_trap_unit.sv */
// machine trap unit
// top level of the machine-mode trap logic, the exception and interrupt
// pickers feed the trap controller, which updates the CSR file
`timescale 1ns/1ps
`default_nettype none

module machine_trap_unit #(
  parameter logic [31:0] reset_mtvec = 32'h0000_0100
) (
  input  wire logic        clk,
  input  wire logic        arst_n,
  input  wire logic [31:0] pc,
  input  wire logic [31:0] bad_addr,
  input  wire logic        mal_insn,
  input  wire logic        fault_insn,
  input  wire logic        illegal_insn,
  input  wire logic        breakpoint,
  input  wire logic        env_m,
  input  wire logic        mal_l,
  input  wire logic        fault_l,
  input  wire logic        mal_s,
  input  wire logic        fault_s,
  input  wire logic        mret,
  output      logic        trap,
  output      logic        redirect,
  output      logic [31:0] redirect_pc,
  input  wire logic        timer_irq,
  input  wire logic        soft_irq,
  input  wire logic        ext_irq,
  input  wire logic        wb_cyc,
  input  wire logic        wb_stb,
  input  wire logic        wb_we,
  input  wire logic [31:0] wb_adr,
  input  wire logic [31:0] wb_dat_w,
  input  wire logic [3:0]  wb_sel,
  output      logic [31:0] wb_dat_r,
  output      logic        wb_ack
);

  logic                        exc_valid;
  machine_trap_pkg::ex_code_t  exc_code;
  logic                        irq_valid;
  machine_trap_pkg::int_code_t irq_code;
  logic [31:0]                 mip;
  logic [31:0]                 mie;
  logic                        mstatus_mie;
  logic [31:0]                 mtvec;
  logic [31:0]                 mepc;
  logic                        trap_take;
  logic                        ret_take;
  machine_trap_pkg::mcause_t   mcause_next;
  logic [31:0]                 mepc_next;
  logic                        mtval_write;
  logic [31:0]                 mtval_next;

  exception_prioritizer u_exc (
    .mal_insn, .fault_insn, .illegal_insn, .breakpoint, .env_m,
    .mal_l, .fault_l, .mal_s, .fault_s,
    .exc_valid, .exc_code
  );

  interrupt_arbiter u_irq (
    .mip, .mie, .mstatus_mie,
    .irq_valid, .irq_code
  );

  trap_control u_ctrl (
    .clk, .arst_n,
    .exc_valid, .exc_code, .irq_valid, .irq_code,
    .breakpoint, .env_m, .mret, .pc, .bad_addr, .mtvec, .mepc,
    .trap, .redirect, .redirect_pc,
    .trap_take, .ret_take, .mcause_next, .mepc_next, .mtval_write, .mtval_next
  );

  machine_csr_file #(
    .reset_mtvec(reset_mtvec)
  ) u_csr (
    .clk, .arst_n,
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_sel, .wb_dat_r, .wb_ack,
    .timer_irq, .soft_irq, .ext_irq,
    .trap_take, .mcause_next, .mepc_next, .mtval_write, .mtval_next, .ret_take,
    .mip, .mie, .mstatus_mie, .mtvec, .mepc
  );

endmodule

`default_nettype wire

/* src/trap_control.sv */
// trap controller
// merges the exception and interrupt requests into one trap decision,
// builds the mcause, mepc and mtval values the CSR file latches and
// picks the next fetch address for a trap or an mret
`timescale 1ns/1ps
`default_nettype none

module trap_control (
  input  wire logic                        clk,
  input  wire logic                        arst_n,
  input  wire logic                        exc_valid,
  input  wire machine_trap_pkg::ex_code_t  exc_code,
  input  wire logic                        irq_valid,
  input  wire machine_trap_pkg::int_code_t irq_code,
  input  wire logic                        breakpoint,
  input  wire logic                        env_m,
  input  wire logic                        mret,
  input  wire logic [31:0]                 pc,
  input  wire logic [31:0]                 bad_addr,
  input  wire logic [31:0]                 mtvec,
  input  wire logic [31:0]                 mepc,
  output      logic                        trap,
  output      logic                        redirect,
  output      logic [31:0]                 redirect_pc,
  output      logic                        trap_take,
  output      logic                        ret_take,
  output      machine_trap_pkg::mcause_t   mcause_next,
  output      logic [31:0]                 mepc_next,
  output      logic                        mtval_write,
  output      logic [31:0]                 mtval_next
);

  logic mem_exc;    // winner is a load or store problem
  logic fetch_exc;  // winner is an instruction fetch problem
  logic skip_insn;  // winner is ebreak or ecall, so return past it

  assign trap      = exc_valid | irq_valid;
  assign trap_take = trap;
  assign ret_take  = mret & ~trap;  // a trap in the same cycle swallows the mret

  assign redirect    = trap | mret;
  assign redirect_pc = trap ? mtvec : mepc;  // mtvec is direct mode only

  assign mem_exc = exc_valid &&
                   (exc_code == machine_trap_pkg::L_FAULT    ||
                    exc_code == machine_trap_pkg::L_ADDR_MAL ||
                    exc_code == machine_trap_pkg::S_FAULT    ||
                    exc_code == machine_trap_pkg::S_ADDR_MAL);
  assign fetch_exc = exc_valid &&
                     (exc_code == machine_trap_pkg::INSN_FAULT ||
                      exc_code == machine_trap_pkg::INSN_MAL);

  // ebreak and ecall outrank everything except memory faults, so with
  // one of their flags up and no memory fault they must be the winner
  assign skip_insn = exc_valid & (breakpoint | env_m) & ~mem_exc;

  // mepc holds the instruction to resume at
  assign mepc_next = skip_insn ? (pc + 32'd4) : pc;

  // exceptions always write mtval, interrupts leave it alone
  assign mtval_write = exc_valid;

  always_comb begin
    if (mem_exc) begin
      mtval_next = bad_addr;  // faulting data address
    end else if (fetch_exc) begin
      mtval_next = pc;  // the fetch address itself
    end else begin
      mtval_next = '0;
    end
  end

  // write through the view that matches the winning request
  always_comb begin
    mcause_next = '0;
    if (exc_valid) begin
      mcause_next.ex.interrupt = 1'b0;
      mcause_next.ex.cause     = exc_code;
    end else begin
      mcause_next.irq.interrupt = 1'b1;
      mcause_next.irq.cause     = irq_code;
    end
  end

  a_trap_ret_exclusive : assert property (@(posedge clk) disable iff (!arst_n)
    !(trap && ret_take))
    else $error("trap and trap return taken in the same cycle");

endmodule

`default_nettype wire
